// File: flist.f
verilog/segDisplayPkg.sv
verilog/regSampler.sv
verilog/binToBcd.sv
verilog/scanTimer.sv
verilog/digitMux.sv
verilog/regToSegment.sv
verification/regToSegment_props.sv
verification/regToSegmentChecker.sv
verification/regToSegmentTb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module regToSegmentTb -o regToSegmentSim

simStatus=0
./obj_dir/regToSegmentSim > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log || [ "$simStatus" -ne 0 ]; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"

// File: verification/regToSegmentChecker.sv
`default_nettype none

module regToSegmentChecker import segDisplayPkg::*; #(
    parameter int NumDigits  = 4,
    parameter int ScanDivide = 3
) (
    input  logic       clock,
    input  logic       rstN,
    input  regWordT    regData,
    input  logic       enable,
    input  anodeVecT   an,
    input  segPatternT seg,
    output logic       settled,
    output int         checkCount,
    output int         valueErrors,
    output int         anodeErrors
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SettleCycles = 40;
    localparam int ScanWindow   = NumDigits * ScanDivide;

    binValueT modelValue;
    logic     modelValid;
    int       quietCount;
    int       darkCycles [NumDigits];

    // lit segments are listed g down to a, then inverted.
    function automatic segPatternT expectedSeg(input binValueT value, input int position);
        int         limit;
        int         digit;
        logic [6:0] lit;
        limit = 1;
        for (int i = 0; i < NumDigits; i++) begin
            limit = limit * 10;
        end
        digit = int'(value);
        for (int i = 0; i < position; i++) begin
            digit = digit / 10;
        end
        case (digit % 10)
            0:       lit = 7'b0111111;
            1:       lit = 7'b0000110;
            2:       lit = 7'b1011011;
            3:       lit = 7'b1001111;
            4:       lit = 7'b1100110;
            5:       lit = 7'b1101101;
            6:       lit = 7'b1111101;
            7:       lit = 7'b0000111;
            8:       lit = 7'b1111111;
            default: lit = 7'b1101111;
        endcase
        if (int'(value) >= limit) begin
            lit = 7'b0001000;  // broken shows segment d only.
        end
        return ~lit;
    endfunction

    always @(posedge clock) begin
        if (!rstN) begin
            modelValid <= 1'b0;
            quietCount <= 0;
        end else if (enable) begin
            modelValue <= regData[15:0];
            modelValid <= 1'b1;
            quietCount <= 0;
        end else if (quietCount < SettleCycles) begin
            quietCount <= quietCount + 1;
        end
    end

    assign settled = modelValid && (quietCount >= SettleCycles);

    // outputs are stable mid cycle.
    always @(negedge clock) begin : compareOutputs
        int         lowCount;
        int         active;
        segPatternT expected;
        if (rstN && !modelValid) begin
            checkCount++;
            if (an !== '1 || seg !== '1) begin
                $display("ERROR: an = %h, seg = %h, expected %h and %h before first sample",
                         an, seg, 8'hff, 7'h7f);
                anodeErrors++;
            end
        end
        if (rstN && settled) begin
            checkCount++;
            lowCount = 0;
            active   = 0;
            for (int i = 0; i < MaxDigits; i++) begin
                if (an[i] !== 1'b1) begin
                    lowCount++;
                    active = i;
                end
            end
            if (lowCount != 1 || active >= NumDigits) begin
                $display("ERROR: an = %h, expected one low bit below bit %0d", an, NumDigits);
                anodeErrors++;
            end else begin
                expected = expectedSeg(modelValue, active);
                if (seg !== expected) begin
                    $display("ERROR: seg = %h, expected %h for value %h on anode %0d",
                             seg, expected, modelValue, active);
                    valueErrors++;
                end
            end
            for (int i = 0; i < NumDigits; i++) begin
                darkCycles[i] = (an[i] === 1'b0) ? 0 : darkCycles[i] + 1;
                if (darkCycles[i] == ScanWindow) begin
                    $display("anode %0d was never active during %0d quiet cycles",
                             i, ScanWindow);
                    anodeErrors++;
                end
            end
        end else begin
            for (int i = 0; i < NumDigits; i++) begin
                darkCycles[i] = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/regToSegmentTb.sv
`default_nettype none

module regToSegmentTb import segDisplayPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumDigits     = 4;
    localparam int ScanDivide    = 3;
    localparam int Bursts        = 40;
    localparam int SettleTimeout = 200;
    localparam int RunLimit      = 100000;

    logic       clock;
    logic       rstN;
    logic       enable;
    regWordT    regData;
    anodeVecT   an;
    segPatternT seg;
    logic       settled;
    int         checkCount;
    int         valueErrors;
    int         anodeErrors;
    int         timeouts;

    regToSegment #(
        .NumDigits  (NumDigits),
        .ScanDivide (ScanDivide)
    ) dut_i (
        .clock   (clock),
        .rstN    (rstN),
        .regData (regData),
        .enable  (enable),
        .an      (an),
        .seg     (seg)
    );

    regToSegmentChecker #(
        .NumDigits  (NumDigits),
        .ScanDivide (ScanDivide)
    ) checker_i (
        .clock       (clock),
        .rstN        (rstN),
        .regData     (regData),
        .enable      (enable),
        .an          (an),
        .seg         (seg),
        .settled     (settled),
        .checkCount  (checkCount),
        .valueErrors (valueErrors),
        .anodeErrors (anodeErrors)
    );

    bind digitMux regToSegmentProps #(.NumDigits(NumDigits)) props_i (
        .clock      (clock),
        .rstN       (rstN),
        .an         (an),
        .bcdDone    (bcdDone),
        .digitIndex (digitIndex)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // mix of small, four-digit and overflowing values.
    function automatic regWordT randomWord();
        binValueT low;
        case ($urandom_range(0, 3))
            0:       low = 16'($urandom_range(0, 99));
            1:       low = 16'($urandom_range(100, 9999));
            2:       low = 16'($urandom_range(10000, 65535));
            default: low = 16'($urandom);
        endcase
        return {16'($urandom), low};
    endfunction

    task automatic holdIdle(input int cycles);
        repeat (cycles) @(posedge clock);
    endtask

    // long pulses keep the converter busy and queue samples.
    task automatic driveBurst();
        int pulses;
        int length;
        pulses = $urandom_range(1, 6);
        for (int p = 0; p < pulses; p++) begin
            length = ($urandom_range(0, 2) == 0) ? $urandom_range(5, 40) : 1;
            repeat (length) begin
                @(posedge clock);
                enable  <= 1'b1;
                regData <= randomWord();
            end
            @(posedge clock);
            enable <= 1'b0;
            repeat ($urandom_range(0, 12)) @(posedge clock);
        end
    endtask

    task automatic waitSettled(input int burst);
        int waited;
        waited = 0;
        while (!settled && waited < SettleTimeout) begin
            @(negedge clock);
            waited++;
        end
        if (!settled) begin
            $display("timeout: display did not settle after burst %0d", burst);
            timeouts++;
        end
    endtask

    initial begin : stimulus
        int burst;
        rstN     = 1'b0;
        enable   = 1'b0;
        regData  = '0;
        timeouts = 0;
        void'($urandom(32'hd206_0154));
        repeat (8) @(posedge clock);
        rstN <= 1'b1;
        holdIdle($urandom_range(20, 40));  // blank display before the first sample.
        for (burst = 0; burst < Bursts && timeouts == 0; burst++) begin
            driveBurst();
            waitSettled(burst);
            @(posedge clock);
            holdIdle($urandom_range(20, 80));
        end
        $display("checks %0d, value errors %0d, anode errors %0d, timeouts %0d",
                 checkCount, valueErrors, anodeErrors, timeouts);
        if (valueErrors == 0 && anodeErrors == 0 && timeouts == 0 && checkCount > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < RunLimit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: simulation did not finish within %0d cycles", RunLimit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/regToSegment_props.sv
`default_nettype none

module regToSegmentProps import segDisplayPkg::*; #(
    parameter int NumDigits = 4
) (
    input logic       clock,
    input logic       rstN,
    input anodeVecT   an,
    input logic       bcdDone,
    input logic [2:0] digitIndex
);
    timeunit 1ns;
    timeprecision 1ps;

    property singleAnode;
        @(posedge clock) disable iff (!rstN) $countones(~an) <= 1;
    endproperty

    property indexInRange;
        @(posedge clock) disable iff (!rstN) digitIndex < 3'(NumDigits);
    endproperty

    property donePulse;
        @(posedge clock) disable iff (!rstN) bcdDone |=> !bcdDone;
    endproperty

    assert property (singleAnode) else $error("two anodes active at once, an = %h", an);
    assert property (indexInRange) else $error("digit index %0d out of range", digitIndex);
    assert property (donePulse) else $error("conversion done held for two cycles");

endmodule

`default_nettype wire

// File: verilog/binToBcd.sv
`default_nettype none

module binToBcd import segDisplayPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    input  binValueT sampleValue,
    input  logic     sampleStrobe,
    output bcdWordT  bcdValue,
    output logic     bcdDone
);

    localparam int ShiftSteps = $bits(binValueT);
    localparam int BcdDigits  = $bits(bcdWordT) / $bits(bcdDigitT);

    convStateT  state;
    logic [3:0] shiftCount;
    binValueT   shiftReg;
    bcdWordT    bcdAcc;
    bcdWordT    bcdAdjusted;
    binValueT   pendingValue;
    logic       pendingValid;
    logic       startConv;
    binValueT   startValue;
    logic       lastShift;

    function automatic bcdWordT addThree(input bcdWordT acc);
        bcdWordT  result;
        bcdDigitT digit;
        result = acc;
        for (int i = 0; i < BcdDigits; i++) begin
            digit = acc[i*4 +: 4];
            if (digit >= 4'd5) begin
                result[i*4 +: 4] = digit + 4'd3;
            end
        end
        return result;
    endfunction

    assign bcdAdjusted = addThree(bcdAcc);
    assign lastShift   = (state == convShift) && (shiftCount == 4'(ShiftSteps - 1));

    // a fresh strobe beats the queued sample.
    always_comb begin
        startConv  = 1'b0;
        startValue = sampleValue;
        case (state)
            convIdle: begin
                startConv = sampleStrobe;
            end
            convFinish: begin
                startConv = sampleStrobe || pendingValid;
                if (!sampleStrobe) begin
                    startValue = pendingValue;
                end
            end
            default: begin
                startConv = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state        <= convIdle;
            shiftCount   <= '0;
            pendingValid <= 1'b0;
            bcdDone      <= 1'b0;
        end else begin
            bcdDone <= (state == convFinish);
            case (state)
                convIdle: begin
                    if (startConv) begin
                        state <= convShift;
                    end
                end
                convShift: begin
                    if (lastShift) begin
                        state <= convFinish;
                    end
                end
                default: begin
                    state <= startConv ? convShift : convIdle;
                end
            endcase
            shiftCount <= (state == convShift) ? shiftCount + 4'd1 : 4'd0;
            if (state == convShift && sampleStrobe) begin
                pendingValid <= 1'b1;  // only the latest is kept.
            end else if (state == convFinish) begin
                pendingValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (startConv) begin
            shiftReg <= startValue;
            bcdAcc   <= '0;
        end else if (state == convShift) begin
            bcdAcc   <= {bcdAdjusted[$bits(bcdWordT)-2:0], shiftReg[ShiftSteps-1]};
            shiftReg <= shiftReg << 1;
        end
        if (state == convShift && sampleStrobe) begin
            pendingValue <= sampleValue;
        end
        if (state == convFinish) begin
            bcdValue <= bcdAcc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/digitMux.sv
`default_nettype none

module digitMux import segDisplayPkg::*; #(
    parameter int NumDigits = 4
) (
    input  logic       clock,
    input  logic       rstN,
    input  bcdWordT    bcdValue,
    input  logic       bcdDone,
    input  logic [2:0] digitIndex,
    output anodeVecT   an,
    output segPatternT seg
);

    localparam int DigitBits = $bits(bcdDigitT);
    localparam int BcdDigits = $bits(bcdWordT) / DigitBits;

    bcdWordT    heldDigits;
    logic       shown;
    logic       overflow;
    bcdDigitT   activeDigit;
    segPatternT digitPattern;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            heldDigits <= '0;
            shown      <= 1'b0;
        end else if (bcdDone) begin
            heldDigits <= bcdValue;
            shown      <= 1'b1;
        end
    end

    // value too wide for the active digits.
    always_comb begin
        overflow = 1'b0;
        for (int i = 0; i < BcdDigits; i++) begin
            if (i >= NumDigits && heldDigits[i*DigitBits +: DigitBits] != '0) begin
                overflow = 1'b1;
            end
        end
    end

    always_comb begin
        activeDigit = '0;
        for (int i = 0; i < BcdDigits; i++) begin
            if (digitIndex == 3'(i)) begin
                activeDigit = heldDigits[i*DigitBits +: DigitBits];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < MaxDigits; i++) begin
            an[i] = !(shown && digitIndex == 3'(i));
        end
    end

    always_comb begin
        case (activeDigit)
            4'd0:    digitPattern = segDigit0;
            4'd1:    digitPattern = segDigit1;
            4'd2:    digitPattern = segDigit2;
            4'd3:    digitPattern = segDigit3;
            4'd4:    digitPattern = segDigit4;
            4'd5:    digitPattern = segDigit5;
            4'd6:    digitPattern = segDigit6;
            4'd7:    digitPattern = segDigit7;
            4'd8:    digitPattern = segDigit8;
            4'd9:    digitPattern = segDigit9;
            default: digitPattern = segBroken;
        endcase
    end

    always_comb begin
        if (!shown) begin
            seg = '1;  // blank until first result.
        end else if (overflow) begin
            seg = segBroken;
        end else begin
            seg = digitPattern;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regSampler.sv
`default_nettype none

module regSampler import segDisplayPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    input  regWordT  regData,
    input  logic     enable,
    output binValueT sampleValue,
    output logic     sampleStrobe
);

    binValueT stageOne;
    logic     stageOneValid;

    // valid bits follow enable through the stages.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            stageOneValid <= 1'b0;
            sampleStrobe  <= 1'b0;
        end else begin
            stageOneValid <= enable;
            sampleStrobe  <= stageOneValid;
        end
    end

    // upper half is not displayed.
    always_ff @(posedge clock) begin
        if (enable) begin
            stageOne <= regData[15:0];
        end
        if (stageOneValid) begin
            sampleValue <= stageOne;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regToSegment.sv
`default_nettype none

module regToSegment import segDisplayPkg::*; #(
    parameter int NumDigits  = 4,
    parameter int ScanDivide = 2048
) (
    input  logic       clock,
    input  logic       rstN,
    input  regWordT    regData,
    input  logic       enable,
    output anodeVecT   an,
    output segPatternT seg
);

    binValueT   sampleValue;
    logic       sampleStrobe;
    bcdWordT    bcdValue;
    logic       bcdDone;
    logic [2:0] digitIndex;

    regSampler sampler_i (
        .clock        (clock),
        .rstN         (rstN),
        .regData      (regData),
        .enable       (enable),
        .sampleValue  (sampleValue),
        .sampleStrobe (sampleStrobe)
    );

    binToBcd converter_i (
        .clock        (clock),
        .rstN         (rstN),
        .sampleValue  (sampleValue),
        .sampleStrobe (sampleStrobe),
        .bcdValue     (bcdValue),
        .bcdDone      (bcdDone)
    );

    scanTimer #(
        .NumDigits  (NumDigits),
        .ScanDivide (ScanDivide)
    ) timer_i (
        .clock      (clock),
        .rstN       (rstN),
        .digitIndex (digitIndex)
    );

    digitMux #(
        .NumDigits (NumDigits)
    ) mux_i (
        .clock      (clock),
        .rstN       (rstN),
        .bcdValue   (bcdValue),
        .bcdDone    (bcdDone),
        .digitIndex (digitIndex),
        .an         (an),
        .seg        (seg)
    );

endmodule

`default_nettype wire

// File: verilog/scanTimer.sv
`default_nettype none

module scanTimer #(
    parameter int NumDigits  = 4,
    parameter int ScanDivide = 2048
) (
    input  logic       clock,
    input  logic       rstN,
    output logic [2:0] digitIndex
);

    localparam int PreWidth = (ScanDivide > 1) ? $clog2(ScanDivide) : 1;

    logic [PreWidth-1:0] prescale;
    logic                prescaleWrap;
    logic                lastDigit;

    assign prescaleWrap = (prescale == PreWidth'(ScanDivide - 1));
    assign lastDigit    = (digitIndex == 3'(NumDigits - 1));

    always_ff @(posedge clock) begin
        if (!rstN) begin
            prescale   <= '0;
            digitIndex <= 3'd0;
        end else begin
            if (prescaleWrap) begin
                prescale <= '0;
            end else begin
                prescale <= prescale + 1'b1;
            end
            // one step per scan slot.
            if (prescaleWrap) begin
                digitIndex <= lastDigit ? 3'd0 : digitIndex + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/segDisplayPkg.sv
`default_nettype none

package segDisplayPkg;

    typedef logic [31:0] regWordT;
    typedef logic [15:0] binValueT;
    typedef logic [3:0]  bcdDigitT;
    typedef logic [19:0] bcdWordT;     // five packed digits.
    typedef logic [6:0]  segPatternT;  // active low, segment a in bit 0.
    typedef logic [7:0]  anodeVecT;    // active low.

    localparam int MaxDigits = 8;      // anodes on the board.

    localparam segPatternT segDigit0 = 7'b1000000;
    localparam segPatternT segDigit1 = 7'b1111001;
    localparam segPatternT segDigit2 = 7'b0100100;
    localparam segPatternT segDigit3 = 7'b0110000;
    localparam segPatternT segDigit4 = 7'b0011001;
    localparam segPatternT segDigit5 = 7'b0010010;
    localparam segPatternT segDigit6 = 7'b0000010;
    localparam segPatternT segDigit7 = 7'b1111000;
    localparam segPatternT segDigit8 = 7'b0000000;
    localparam segPatternT segDigit9 = 7'b0010000;
    localparam segPatternT segBroken = 7'b1110111;  // only segment d lit.

    typedef enum logic [1:0] {
        convIdle,
        convShift,
        convFinish
    } convStateT;

endpackage

`default_nettype wire
